// ==== design/bus_sram.sv ====
`timescale 1ns/1ps

module bus_sram
#(
	parameter int MEM_WORDS = 1024
)
(
	input  logic clk_i
	, input  logic srst_i

	, input  logic                        req_i
	, input  logic                        we_i
	, input  logic [mpss_pkg::ADDR_W-1:0] addr_i
	, input  logic [mpss_pkg::BE_W-1:0]   be_i
	, input  logic [mpss_pkg::DATA_W-1:0] wdata_i
	, output logic                        ack_o
	, output logic                        resp_o
	, output logic [mpss_pkg::DATA_W-1:0] rdata_o
);

	import mpss_pkg::*;

	localparam int IDX_W = $clog2(MEM_WORDS);

	logic [DATA_W-1:0] mem [MEM_WORDS];
	logic [ADDR_W-3:0] word_addr;
	logic [IDX_W-1:0]  idx;
	logic [DATA_W-1:0] rdata_q;
	logic              resp_q;

	assign word_addr = addr_i[ADDR_W-1:2];
	assign idx       = IDX_W'(word_addr % (ADDR_W-2)'(MEM_WORDS)); // Wraps over the array
	assign ack_o     = req_i; // Never stalls

	always_ff @(posedge clk_i) begin
		if (req_i && we_i) begin
			for (int b = 0; b < BE_W; b++) begin
				if (be_i[b]) begin
					mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
				end
			end
		end
		if (req_i && !we_i) begin
			rdata_q <= mem[idx];
		end
	end

	always_ff @(posedge clk_i) begin
		if (srst_i) begin
			resp_q <= 1'b0;
		end else begin
			resp_q <= req_i && !we_i;
		end
	end

	assign resp_o  = resp_q;
	assign rdata_o = rdata_q;

endmodule

// ==== design/bus_xbar.sv ====
`timescale 1ns/1ps

module bus_xbar
(
	input  logic clk_i
	, input  logic srst_i

	, input  logic                        m0_req_i
	, input  logic                        m0_we_i
	, input  logic [mpss_pkg::ADDR_W-1:0] m0_addr_i
	, input  logic [mpss_pkg::BE_W-1:0]   m0_be_i
	, input  logic [mpss_pkg::DATA_W-1:0] m0_wdata_i
	, output logic                        m0_ack_o
	, output logic                        m0_resp_o
	, output logic [mpss_pkg::DATA_W-1:0] m0_rdata_o

	, input  logic                        m1_req_i
	, input  logic                        m1_we_i
	, input  logic [mpss_pkg::ADDR_W-1:0] m1_addr_i
	, input  logic [mpss_pkg::BE_W-1:0]   m1_be_i
	, input  logic [mpss_pkg::DATA_W-1:0] m1_wdata_i
	, output logic                        m1_ack_o
	, output logic                        m1_resp_o
	, output logic [mpss_pkg::DATA_W-1:0] m1_rdata_o

	, output logic                        s0_req_o
	, output logic                        s0_we_o
	, output logic [mpss_pkg::ADDR_W-1:0] s0_addr_o
	, output logic [mpss_pkg::BE_W-1:0]   s0_be_o
	, output logic [mpss_pkg::DATA_W-1:0] s0_wdata_o
	, input  logic                        s0_ack_i
	, input  logic                        s0_resp_i
	, input  logic [mpss_pkg::DATA_W-1:0] s0_rdata_i

	, output logic                        s1_req_o
	, output logic                        s1_we_o
	, output logic [mpss_pkg::ADDR_W-1:0] s1_addr_o
	, output logic [mpss_pkg::BE_W-1:0]   s1_be_o
	, output logic [mpss_pkg::DATA_W-1:0] s1_wdata_o
	, input  logic                        s1_ack_i
	, input  logic                        s1_resp_i
	, input  logic [mpss_pkg::DATA_W-1:0] s1_rdata_i
);

	import mpss_pkg::*;

	logic [1:0]          m_req;
	logic [1:0]          m_we;
	logic [ADDR_W-1:0]   m_addr [2];
	logic [BE_W-1:0]     m_be [2];
	logic [DATA_W-1:0]   m_wdata [2];
	logic [REGION_W-1:0] region [2];
	logic [1:0]          m_ack;
	logic [1:0]          m_resp;
	logic [DATA_W-1:0]   m_rdata [2];

	logic [1:0]        s_req;
	logic [1:0]        s_we;
	logic [ADDR_W-1:0] s_addr [2];
	logic [BE_W-1:0]   s_be [2];
	logic [DATA_W-1:0] s_wdata [2];
	logic [1:0]        s_ack;
	logic [1:0]        s_resp;
	logic [DATA_W-1:0] s_rdata [2];

	logic [1:0] want [2]; // Indexed [slave][master]
	logic [1:0] gnt [2];
	logic [1:0] unmapped;
	logic [1:0] last_gnt; // Per slave, set when m1 was served last
	logic [1:0] owner;    // Per slave, master of the read in flight
	logic [1:0] unm_pend;

	// When both ask, the master not served last wins
	function automatic logic [1:0] rr_pick(input logic [1:0] req, input logic last);
		logic [1:0] pick;
		pick = req;
		if (req == 2'b11) begin
			pick = last ? 2'b01 : 2'b10;
		end
		return pick;
	endfunction

	assign m_req      = {m1_req_i, m0_req_i} & {2{!srst_i}}; // Nothing is acked during reset
	assign m_we       = {m1_we_i, m0_we_i};
	assign m_addr[0]  = m0_addr_i;
	assign m_addr[1]  = m1_addr_i;
	assign m_be[0]    = m0_be_i;
	assign m_be[1]    = m1_be_i;
	assign m_wdata[0] = m0_wdata_i;
	assign m_wdata[1] = m1_wdata_i;
	assign s_ack      = {s1_ack_i, s0_ack_i};
	assign s_resp     = {s1_resp_i, s0_resp_i};
	assign s_rdata[0] = s0_rdata_i;
	assign s_rdata[1] = s1_rdata_i;

	always_comb begin
		for (int m = 0; m < 2; m++) begin
			region[m]  = m_addr[m][ADDR_W-1 -: REGION_W];
			want[0][m] = m_req[m] && (region[m] == REGION_SRAM);
			want[1][m] = m_req[m] && (region[m] == REGION_GPIO);
		end
	end

	// Anything outside the two regions is answered here
	assign unmapped = m_req & ~(want[0] | want[1]);

	always_comb begin
		for (int s = 0; s < 2; s++) begin
			gnt[s]     = rr_pick(want[s], last_gnt[s]);
			s_req[s]   = |gnt[s];
			s_we[s]    = gnt[s][1] ? m_we[1] : m_we[0];
			s_addr[s]  = gnt[s][1] ? m_addr[1] : m_addr[0];
			s_be[s]    = gnt[s][1] ? m_be[1] : m_be[0];
			s_wdata[s] = gnt[s][1] ? m_wdata[1] : m_wdata[0];
		end
	end

	always_comb begin
		for (int m = 0; m < 2; m++) begin
			m_ack[m]   = (gnt[0][m] & s_ack[0]) | (gnt[1][m] & s_ack[1]) | unmapped[m];
			m_resp[m]  = unm_pend[m];
			m_rdata[m] = UNMAPPED_RDATA;
			for (int s = 0; s < 2; s++) begin
				if (s_resp[s] && (owner[s] == 1'(m))) begin
					m_resp[m]  = 1'b1;
					m_rdata[m] = s_rdata[s];
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (srst_i) begin
			last_gnt <= '0;
			owner    <= '0;
			unm_pend <= '0;
		end else begin
			for (int s = 0; s < 2; s++) begin
				if (s_req[s] && s_ack[s]) begin
					last_gnt[s] <= gnt[s][1];
					if (!s_we[s]) begin
						owner[s] <= gnt[s][1]; // Slave answers one edge later
					end
				end
			end
			unm_pend <= unmapped & ~m_we;
		end
	end

	assign s0_req_o   = s_req[0];
	assign s0_we_o    = s_we[0];
	assign s0_addr_o  = s_addr[0];
	assign s0_be_o    = s_be[0];
	assign s0_wdata_o = s_wdata[0];
	assign s1_req_o   = s_req[1];
	assign s1_we_o    = s_we[1];
	assign s1_addr_o  = s_addr[1];
	assign s1_be_o    = s_be[1];
	assign s1_wdata_o = s_wdata[1];

	assign m0_ack_o   = m_ack[0];
	assign m0_resp_o  = m_resp[0];
	assign m0_rdata_o = m_rdata[0];
	assign m1_ack_o   = m_ack[1];
	assign m1_resp_o  = m_resp[1];
	assign m1_rdata_o = m_rdata[1];

endmodule

// ==== design/gpio_port.sv ====
`timescale 1ns/1ps

module gpio_port
(
	input  logic clk_i
	, input  logic srst_i

	, input  logic [mpss_pkg::DATA_W-1:0] gpio_i
	, input  logic [mpss_pkg::DATA_W-1:0] out_value_i
	, input  logic [mpss_pkg::DATA_W-1:0] dir_mask_i
	, output logic [mpss_pkg::DATA_W-1:0] gpio_o
	, output logic [mpss_pkg::DATA_W-1:0] in_sync_o
	, output logic [mpss_pkg::DATA_W-1:0] rise_o
);

	import mpss_pkg::*;

	logic [DATA_W-1:0] meta_q;
	logic [DATA_W-1:0] sync_q;
	logic [DATA_W-1:0] prev_q; // Last synchronized sample
	logic [DATA_W-1:0] pin_q;

	always_ff @(posedge clk_i) begin
		if (srst_i) begin
			meta_q <= '0;
			sync_q <= '0;
			prev_q <= '0;
			pin_q  <= '0;
		end else begin
			meta_q <= gpio_i;
			sync_q <= meta_q;
			prev_q <= sync_q;
			pin_q  <= out_value_i & dir_mask_i; // Input pins drive low
		end
	end

	assign in_sync_o = sync_q;
	assign rise_o    = sync_q & ~prev_q;
	assign gpio_o    = pin_q;

endmodule

// ==== design/gpio_regs.sv ====
`timescale 1ns/1ps

module gpio_regs
(
	input  logic clk_i
	, input  logic srst_i

	, input  logic                        req_i
	, input  logic                        we_i
	, input  logic [mpss_pkg::ADDR_W-1:0] addr_i
	, input  logic [mpss_pkg::BE_W-1:0]   be_i
	, input  logic [mpss_pkg::DATA_W-1:0] wdata_i
	, output logic                        ack_o
	, output logic                        resp_o
	, output logic [mpss_pkg::DATA_W-1:0] rdata_o

	, input  logic [mpss_pkg::DATA_W-1:0] in_sync_i
	, input  logic [mpss_pkg::DATA_W-1:0] rise_i
	, output logic [mpss_pkg::DATA_W-1:0] out_value_o
	, output logic [mpss_pkg::DATA_W-1:0] dir_mask_o
);

	import mpss_pkg::*;

	logic [GPIO_OFS_W-1:0] ofs;
	logic                  wr;
	logic [DATA_W-1:0]     be_mask;
	logic [DATA_W-1:0]     edge_clr;
	logic [DATA_W-1:0]     rd_word;
	logic [DATA_W-1:0]     out_q;
	logic [DATA_W-1:0]     dir_q;
	logic [DATA_W-1:0]     edge_q;
	logic [DATA_W-1:0]     rdata_q;
	logic                  resp_q;

	assign ofs   = addr_i[GPIO_OFS_W-1:0];
	assign wr    = req_i && we_i;
	assign ack_o = req_i;

	always_comb begin
		for (int b = 0; b < BE_W; b++) begin
			be_mask[8*b +: 8] = {8{be_i[b]}};
		end
	end

	assign edge_clr = (wr && ofs == GPIO_EDGE_OFS) ? (wdata_i & be_mask) : '0;

	always_comb begin
		case (ofs)
			GPIO_OUT_OFS:  rd_word = out_q;
			GPIO_DIR_OFS:  rd_word = dir_q;
			GPIO_IN_OFS:   rd_word = in_sync_i;
			GPIO_EDGE_OFS: rd_word = edge_q;
			default:       rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (srst_i) begin
			out_q  <= '0;
			dir_q  <= '0;
			edge_q <= '0;
			resp_q <= 1'b0;
		end else begin
			resp_q <= req_i && !we_i;
			if (wr && ofs == GPIO_OUT_OFS) begin
				out_q <= (out_q & ~be_mask) | (wdata_i & be_mask);
			end
			if (wr && ofs == GPIO_DIR_OFS) begin
				dir_q <= (dir_q & ~be_mask) | (wdata_i & be_mask);
			end
			edge_q <= (edge_q & ~edge_clr) | rise_i; // A fresh edge beats the clear
		end
	end

	always_ff @(posedge clk_i) begin
		if (req_i && !we_i) begin
			rdata_q <= rd_word;
		end
	end

	assign resp_o      = resp_q;
	assign rdata_o     = rdata_q;
	assign out_value_o = out_q;
	assign dir_mask_o  = dir_q;

endmodule

// ==== design/mpss_lite.sv ====
`timescale 1ns/1ps

module mpss_lite
#(
	parameter int MEM_WORDS = 1024
)
(
	input  logic clk_i
	, input  logic rst_n_i

	, input  logic                        m0_req_i
	, input  logic                        m0_we_i
	, input  logic [mpss_pkg::ADDR_W-1:0] m0_addr_i
	, input  logic [mpss_pkg::BE_W-1:0]   m0_be_i
	, input  logic [mpss_pkg::DATA_W-1:0] m0_wdata_i
	, output logic                        m0_ack_o
	, output logic                        m0_resp_o
	, output logic [mpss_pkg::DATA_W-1:0] m0_rdata_o

	, input  logic                        m1_req_i
	, input  logic                        m1_we_i
	, input  logic [mpss_pkg::ADDR_W-1:0] m1_addr_i
	, input  logic [mpss_pkg::BE_W-1:0]   m1_be_i
	, input  logic [mpss_pkg::DATA_W-1:0] m1_wdata_i
	, output logic                        m1_ack_o
	, output logic                        m1_resp_o
	, output logic [mpss_pkg::DATA_W-1:0] m1_rdata_o

	, input  logic [31:0] gpio_i
	, output logic [31:0] gpio_o
);

	import mpss_pkg::*;

	logic srst;

	// Memory port
	logic              s0_req;
	logic              s0_we;
	logic [ADDR_W-1:0] s0_addr;
	logic [BE_W-1:0]   s0_be;
	logic [DATA_W-1:0] s0_wdata;
	logic              s0_ack;
	logic              s0_resp;
	logic [DATA_W-1:0] s0_rdata;

	// GPIO port
	logic              s1_req;
	logic              s1_we;
	logic [ADDR_W-1:0] s1_addr;
	logic [BE_W-1:0]   s1_be;
	logic [DATA_W-1:0] s1_wdata;
	logic              s1_ack;
	logic              s1_resp;
	logic [DATA_W-1:0] s1_rdata;

	logic [DATA_W-1:0] out_value;
	logic [DATA_W-1:0] dir_mask;
	logic [DATA_W-1:0] in_sync;
	logic [DATA_W-1:0] rise;

	reset_sync u_reset_sync
	(
		.clk_i(clk_i)
		, .rst_n_i(rst_n_i)
		, .srst_o(srst)
	);

	bus_xbar u_bus_xbar
	(
		.clk_i(clk_i)
		, .srst_i(srst)

		, .m0_req_i   (m0_req_i)
		, .m0_we_i    (m0_we_i)
		, .m0_addr_i  (m0_addr_i)
		, .m0_be_i    (m0_be_i)
		, .m0_wdata_i (m0_wdata_i)
		, .m0_ack_o   (m0_ack_o)
		, .m0_resp_o  (m0_resp_o)
		, .m0_rdata_o (m0_rdata_o)

		, .m1_req_i   (m1_req_i)
		, .m1_we_i    (m1_we_i)
		, .m1_addr_i  (m1_addr_i)
		, .m1_be_i    (m1_be_i)
		, .m1_wdata_i (m1_wdata_i)
		, .m1_ack_o   (m1_ack_o)
		, .m1_resp_o  (m1_resp_o)
		, .m1_rdata_o (m1_rdata_o)

		, .s0_req_o   (s0_req)
		, .s0_we_o    (s0_we)
		, .s0_addr_o  (s0_addr)
		, .s0_be_o    (s0_be)
		, .s0_wdata_o (s0_wdata)
		, .s0_ack_i   (s0_ack)
		, .s0_resp_i  (s0_resp)
		, .s0_rdata_i (s0_rdata)

		, .s1_req_o   (s1_req)
		, .s1_we_o    (s1_we)
		, .s1_addr_o  (s1_addr)
		, .s1_be_o    (s1_be)
		, .s1_wdata_o (s1_wdata)
		, .s1_ack_i   (s1_ack)
		, .s1_resp_i  (s1_resp)
		, .s1_rdata_i (s1_rdata)
	);

	bus_sram #(
		.MEM_WORDS(MEM_WORDS)
	) u_bus_sram (
		.clk_i(clk_i)
		, .srst_i(srst)

		, .req_i   (s0_req)
		, .we_i    (s0_we)
		, .addr_i  (s0_addr)
		, .be_i    (s0_be)
		, .wdata_i (s0_wdata)
		, .ack_o   (s0_ack)
		, .resp_o  (s0_resp)
		, .rdata_o (s0_rdata)
	);

	gpio_regs u_gpio_regs
	(
		.clk_i(clk_i)
		, .srst_i(srst)

		, .req_i   (s1_req)
		, .we_i    (s1_we)
		, .addr_i  (s1_addr)
		, .be_i    (s1_be)
		, .wdata_i (s1_wdata)
		, .ack_o   (s1_ack)
		, .resp_o  (s1_resp)
		, .rdata_o (s1_rdata)

		, .in_sync_i   (in_sync)
		, .rise_i      (rise)
		, .out_value_o (out_value)
		, .dir_mask_o  (dir_mask)
	);

	gpio_port u_gpio_port
	(
		.clk_i(clk_i)
		, .srst_i(srst)

		, .gpio_i      (gpio_i)
		, .out_value_i (out_value)
		, .dir_mask_i  (dir_mask)
		, .gpio_o      (gpio_o)
		, .in_sync_o   (in_sync)
		, .rise_o      (rise)
	);

endmodule

// ==== design/mpss_pkg.sv ====
package mpss_pkg;

	// Bus geometry shared by every master and slave port
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int BE_W   = 4;

	// Address map, the top nibble of the address picks the target
	localparam int REGION_W = 4;
	localparam logic [REGION_W-1:0] REGION_SRAM = 4'h0;
	localparam logic [REGION_W-1:0] REGION_GPIO = 4'h1;

	// GPIO register offsets, decoded from the low address byte
	localparam int GPIO_OFS_W = 8;
	localparam logic [GPIO_OFS_W-1:0] GPIO_OUT_OFS  = 8'h00;
	localparam logic [GPIO_OFS_W-1:0] GPIO_DIR_OFS  = 8'h04;
	localparam logic [GPIO_OFS_W-1:0] GPIO_IN_OFS   = 8'h08;
	localparam logic [GPIO_OFS_W-1:0] GPIO_EDGE_OFS = 8'h0C; // Sticky rise flags, write 1 to clear

	localparam logic [DATA_W-1:0] UNMAPPED_RDATA = '0;

endpackage

// ==== design/reset_sync.sv ====
`timescale 1ns/1ps

module reset_sync
(
	input  logic clk_i
	, input  logic rst_n_i
	, output logic srst_o
);

	logic [1:0] sync_q;

	// Assert at once, release after two clean edges
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sync_q <= 2'b11;
		end else begin
			sync_q <= {sync_q[0], 1'b0};
		end
	end

	assign srst_o = sync_q[1];

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_mpss -o tb_mpss_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_mpss_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" sim.log; then
	exit 1
fi
if ! grep -q "Regression passed" sim.log; then
	echo "No result found in sim.log"
	exit 1
fi
exit 0

// ==== sim.f ====
design/mpss_pkg.sv
design/reset_sync.sv
design/bus_xbar.sv
design/bus_sram.sv
design/gpio_regs.sv
design/gpio_port.sv
design/mpss_lite.sv
verif/mpss_assertions.sv
verif/mpss_checker.sv
verif/tb_mpss.sv

// ==== verif/mpss_assertions.sv ====
`timescale 1ns/1ps

module mpss_assertions
(
	input  logic clk_i
	, input  logic srst_i
	, input  logic        m0_req_i
	, input  logic        m0_we_i
	, input  logic [31:0] m0_addr_i
	, input  logic [3:0]  m0_be_i
	, input  logic [31:0] m0_wdata_i
	, input  logic        m0_ack_o
	, input  logic        m0_resp_o
	, input  logic        m1_req_i
	, input  logic        m1_we_i
	, input  logic [31:0] m1_addr_i
	, input  logic [3:0]  m1_be_i
	, input  logic [31:0] m1_wdata_i
	, input  logic        m1_ack_o
	, input  logic        m1_resp_o
);

	// A master that loses arbitration is served on the next cycle
	a_m0_ack_wait: assert property (@(posedge clk_i) disable iff (srst_i)
		m0_req_i && !m0_ack_o |=> m0_ack_o)
		else $error("m0 waited more than one cycle for ack");
	a_m1_ack_wait: assert property (@(posedge clk_i) disable iff (srst_i)
		m1_req_i && !m1_ack_o |=> m1_ack_o)
		else $error("m1 waited more than one cycle for ack");

	// A waiting master keeps its request and payload until ack
	a_m0_hold: assert property (@(posedge clk_i) disable iff (srst_i)
		m0_req_i && !m0_ack_o |=> m0_req_i && $stable(m0_we_i) && $stable(m0_addr_i)
		&& $stable(m0_be_i) && $stable(m0_wdata_i))
		else $error("m0 request changed before ack");
	a_m1_hold: assert property (@(posedge clk_i) disable iff (srst_i)
		m1_req_i && !m1_ack_o |=> m1_req_i && $stable(m1_we_i) && $stable(m1_addr_i)
		&& $stable(m1_be_i) && $stable(m1_wdata_i))
		else $error("m1 request changed before ack");

	// One read in flight per master, so two responses in a row mean a duplicate
	a_m0_resp_once: assert property (@(posedge clk_i) disable iff (srst_i) m0_resp_o |=> !m0_resp_o)
		else $error("m0 got two responses for one read");
	a_m1_resp_once: assert property (@(posedge clk_i) disable iff (srst_i) m1_resp_o |=> !m1_resp_o)
		else $error("m1 got two responses for one read");

endmodule

bind bus_xbar mpss_assertions u_mpss_assertions
(
	.clk_i(clk_i)
	, .srst_i(srst_i)
	, .m0_req_i(m0_req_i)
	, .m0_we_i(m0_we_i)
	, .m0_addr_i(m0_addr_i)
	, .m0_be_i(m0_be_i)
	, .m0_wdata_i(m0_wdata_i)
	, .m0_ack_o(m0_ack_o)
	, .m0_resp_o(m0_resp_o)
	, .m1_req_i(m1_req_i)
	, .m1_we_i(m1_we_i)
	, .m1_addr_i(m1_addr_i)
	, .m1_be_i(m1_be_i)
	, .m1_wdata_i(m1_wdata_i)
	, .m1_ack_o(m1_ack_o)
	, .m1_resp_o(m1_resp_o)
);

// ==== verif/mpss_checker.sv ====
`timescale 1ns/1ps

module mpss_checker
(
	input  logic clk_i
	, input  logic        m0_ack_i
	, input  logic        m0_resp_i
	, input  logic [31:0] m0_rdata_i
	, input  logic        m1_ack_i
	, input  logic        m1_resp_i
	, input  logic [31:0] m1_rdata_i
	, input  logic [31:0] dut_gpio_i
	, output logic        timeout_o
);

	logic [31:0] exp0_q [$];
	logic [31:0] exp1_q [$];
	int cycles = 0;
	int limit = 0;
	int test_errs = 0;
	int total_errs = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;

	initial timeout_o = 1'b0;

	task automatic report_fail(input string msg);
		$display("%s", msg);
		test_errs++;
		total_errs++;
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %08h actual %08h", $time, name, exp, act);
			test_errs++;
			total_errs++;
		end
	endtask

	task automatic set_limit(input int n);
		limit = n;
	endtask

	task automatic expect_read(input int m, input logic [31:0] exp);
		if (m == 0) begin
			exp0_q.push_back(exp);
		end else begin
			exp1_q.push_back(exp);
		end
	endtask

	// Output register follows a write after two edges
	task automatic check_gpio(input logic [31:0] exp);
		repeat (2) @(posedge clk_i);
		compare("gpio_o", exp, dut_gpio_i);
	endtask

	task automatic check_idle();
		compare("m0_ack_o", 32'd0, {31'd0, m0_ack_i});
		compare("m1_ack_o", 32'd0, {31'd0, m1_ack_i});
		compare("m0_resp_o", 32'd0, {31'd0, m0_resp_i});
		compare("m1_resp_o", 32'd0, {31'd0, m1_resp_i});
		compare("gpio_o", 32'd0, dut_gpio_i);
	endtask

	task automatic end_test(input int t);
		if (exp0_q.size() != 0 || exp1_q.size() != 0) begin
			report_fail($sformatf("Test %0d ended with reads still waiting for a response", t));
			exp0_q.delete();
			exp1_q.delete();
		end
		if (test_errs == 0) begin
			$display("Test %0d passed", t);
			pass_cnt++;
		end else begin
			$display("Test %0d failed with %0d errors", t, test_errs);
			fail_cnt++;
		end
		test_errs = 0;
	endtask

	always @(posedge clk_i) begin
		if (m0_resp_i) begin
			if (exp0_q.size() == 0) begin
				report_fail($sformatf("Response on master 0 at %0t with no read outstanding", $time));
			end else begin
				compare("m0_rdata_o", exp0_q.pop_front(), m0_rdata_i);
			end
		end
		if (m1_resp_i) begin
			if (exp1_q.size() == 0) begin
				report_fail($sformatf("Response on master 1 at %0t with no read outstanding", $time));
			end else begin
				compare("m1_rdata_o", exp1_q.pop_front(), m1_rdata_i);
			end
		end
	end

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit && !timeout_o) begin
			$display("Timeout, the run did not finish within %0d cycles", limit);
			timeout_o <= 1'b1;
		end
	end

endmodule

// ==== verif/mpss_trace.txt ====
# test who op addr be data expected
# who 0/1 is a bus master, G the pins; op W write, R read, I drive gpio_i, C check gpio_o
1 0 W 00000010 f deadbeef 00000000
1 0 R 00000010 f 00000000 deadbeef
1 0 W 00000010 3 0000cafe 00000000
1 0 R 00000010 f 00000000 deadcafe
1 1 W 00000014 f 11223344 00000000
1 1 W 00000014 c 77660000 00000000
1 1 R 00000014 f 00000000 77663344
2 0 W 00000100 f 11111111 00000000
2 1 W 00000104 f 22222222 00000000
2 0 R 00000100 f 00000000 11111111
2 1 R 00000104 f 00000000 22222222
3 0 W 10000004 f 0000ff0f 00000000
3 0 W 10000000 f 12345678 00000000
3 G C 00000000 0 00000000 00005608
3 0 R 10000000 f 00000000 12345678
3 0 R 10000004 f 00000000 0000ff0f
4 G I 00000000 0 000000a5 00000000
4 0 R 10000008 f 00000000 000000a5
4 0 R 1000000c f 00000000 000000a5
4 0 W 1000000c f 00000001 00000000
4 0 R 1000000c f 00000000 000000a4
5 0 W 00000040 f 55aa55aa 00000000
5 0 W 20000040 f ffffffff 00000000
5 0 R 20000040 f 00000000 00000000
5 0 R 00000040 f 00000000 55aa55aa
5 1 W 00000200 f a5a5f00d 00000000
6 0 R 10000000 f 00000000 12345678
6 1 R 00000200 f 00000000 a5a5f00d

// ==== verif/tb_mpss.sv ====
`timescale 1ns/1ps

module tb_mpss;

	localparam int OP_WAIT = 20; // Cycles a single handshake may take

	logic        clk;
	logic        rst_n;
	logic        m0_req, m1_req, m0_we, m1_we;
	logic [31:0] m0_addr, m1_addr, m0_wdata, m1_wdata;
	logic [3:0]  m0_be, m1_be;
	logic        m0_ack, m1_ack, m0_resp, m1_resp;
	logic [31:0] m0_rdata, m1_rdata;
	logic [31:0] gpio_in, gpio_out;
	logic        timeout;

	int          op_test [$];
	string       op_who [$];
	string       op_kind [$];
	logic [31:0] op_addr [$];
	logic [3:0]  op_be [$];
	logic [31:0] op_data [$];
	logic [31:0] op_exp [$];
	int          stream0 [$];
	int          stream1 [$];

	mpss_lite #(
		.MEM_WORDS(1024)
	) u_mpss_lite (
		.clk_i(clk), .rst_n_i(rst_n)
		, .m0_req_i(m0_req), .m0_we_i(m0_we), .m0_addr_i(m0_addr), .m0_be_i(m0_be)
		, .m0_wdata_i(m0_wdata), .m0_ack_o(m0_ack), .m0_resp_o(m0_resp), .m0_rdata_o(m0_rdata)
		, .m1_req_i(m1_req), .m1_we_i(m1_we), .m1_addr_i(m1_addr), .m1_be_i(m1_be)
		, .m1_wdata_i(m1_wdata), .m1_ack_o(m1_ack), .m1_resp_o(m1_resp), .m1_rdata_o(m1_rdata)
		, .gpio_i(gpio_in), .gpio_o(gpio_out)
	);

	mpss_checker u_checker
	(
		.clk_i(clk)
		, .m0_ack_i(m0_ack), .m0_resp_i(m0_resp), .m0_rdata_i(m0_rdata)
		, .m1_ack_i(m1_ack), .m1_resp_i(m1_resp), .m1_rdata_i(m1_rdata)
		, .dut_gpio_i(gpio_out), .timeout_o(timeout)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic load_trace();
		int fd;
		int t;
		string line, who, kind;
		logic [31:0] addr, be, data, exp;
		fd = $fopen("verif/mpss_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			if ($sscanf(line, "%d %s %s %h %h %h %h", t, who, kind, addr, be, data, exp) == 7) begin
				op_test.push_back(t);
				op_who.push_back(who);
				op_kind.push_back(kind);
				op_addr.push_back(addr);
				op_be.push_back(be[3:0]);
				op_data.push_back(data);
				op_exp.push_back(exp);
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_master(input int m, input logic req, input logic we,
		input logic [31:0] addr, input logic [3:0] be, input logic [31:0] wdata);
		if (m == 0) begin
			m0_req <= req;
			m0_we <= we;
			m0_addr <= addr;
			m0_be <= be;
			m0_wdata <= wdata;
		end else begin
			m1_req <= req;
			m1_we <= we;
			m1_addr <= addr;
			m1_be <= be;
			m1_wdata <= wdata;
		end
	endtask

	task automatic bus_op(input int m, input int k);
		int waited;
		logic seen;
		logic we;
		we = (op_kind[k] == "W");
		if (!we) u_checker.expect_read(m, op_exp[k]);
		@(posedge clk);
		drive_master(m, 1'b1, we, op_addr[k], op_be[k], op_data[k]);
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < OP_WAIT) begin
			@(posedge clk);
			waited++;
			seen = (m == 0) ? m0_ack : m1_ack;
		end
		drive_master(m, 1'b0, we, op_addr[k], op_be[k], op_data[k]); // Request taken at this edge
		if (!seen) begin
			u_checker.report_fail($sformatf("Master %0d got no ack for trace op %0d", m, k));
			return;
		end
		if (!we) begin
			waited = 0;
			seen = 1'b0;
			while (!seen && waited < OP_WAIT) begin
				@(posedge clk);
				waited++;
				seen = (m == 0) ? m0_resp : m1_resp;
			end
			if (!seen) begin
				u_checker.report_fail($sformatf("Master %0d got no response for op %0d",
					m, k));
			end
		end
	endtask

	task automatic run_stream(input int m);
		int n;
		int k;
		n = (m == 0) ? stream0.size() : stream1.size();
		for (int i = 0; i < n; i++) begin
			k = (m == 0) ? stream0[i] : stream1[i];
			if (i > 0) repeat ($urandom % 4) @(posedge clk);
			if (op_kind[k] == "I") begin
				@(posedge clk);
				gpio_in <= op_data[k];
				repeat (3) @(posedge clk); // Two-flop sync plus the edge register
			end else if (op_kind[k] == "C") begin
				u_checker.check_gpio(op_exp[k]);
			end else begin
				bus_op(m, k);
			end
		end
	endtask

	initial begin
		int idx;
		int t;
		void'($urandom(86267));
		rst_n = 1'b0;
		m0_req = 1'b0;
		m0_we = 1'b0;
		m0_addr = '0;
		m0_be = '0;
		m0_wdata = '0;
		m1_req = 1'b0;
		m1_we = 1'b0;
		m1_addr = '0;
		m1_be = '0;
		m1_wdata = '0;
		gpio_in = '0;
		load_trace();
		u_checker.set_limit(op_test.size() * 20 + 100);
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk);
		u_checker.check_idle();
		idx = 0;
		while (idx < op_test.size()) begin
			t = op_test[idx];
			stream0.delete();
			stream1.delete();
			while (idx < op_test.size() && op_test[idx] == t) begin
				if (op_who[idx] == "1") stream1.push_back(idx);
				else stream0.push_back(idx); // Pin actions run in master 0 order
				idx++;
			end
			fork
				run_stream(0);
				run_stream(1);
			join
			@(posedge clk);
			u_checker.end_test(t);
		end
		repeat (5) @(posedge clk);
		$display("Tests: %0d passed, %0d failed", u_checker.pass_cnt, u_checker.fail_cnt);
		if (u_checker.fail_cnt == 0 && u_checker.total_errs == 0 && op_test.size() > 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		wait (timeout);
		$display("Tests: %0d passed, %0d failed", u_checker.pass_cnt, u_checker.fail_cnt);
		$display("Regression failed");
		$finish;
	end

endmodule
